//--- hw/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

   // Datapath widths
   localparam int data_w = 32;
   localparam int tag_w  = 6;
   localparam int op_w   = 4;

   // Grant to CDB broadcast, in cycles
   localparam int lat_int  = 2;
   localparam int lat_ls   = 2;
   localparam int lat_mult = 5;
   localparam int lat_div  = 8;

   // One bit per future CDB cycle, the divider reaches furthest
   localparam int slot_count = lat_div;

   // Divider retires this many quotient bits per cycle
   localparam int div_bits  = 4;
   localparam int div_cnt_w = $clog2(lat_div);

   // Load/store data store
   localparam int mem_depth = 16;
   localparam int mem_aw    = $clog2(mem_depth);

   // Integer ALU opcodes
   localparam logic [op_w-1:0] op_add   = 4'h0;
   localparam logic [op_w-1:0] op_sub   = 4'h1;
   localparam logic [op_w-1:0] op_and   = 4'h2;
   localparam logic [op_w-1:0] op_or    = 4'h3;
   localparam logic [op_w-1:0] op_xor   = 4'h4;
   localparam logic [op_w-1:0] op_slt   = 4'h5;
   // Branches, resolved on the integer ALU
   localparam logic [op_w-1:0] op_beq   = 4'h6;
   localparam logic [op_w-1:0] op_bne   = 4'h7;
   // Long latency units
   localparam logic [op_w-1:0] op_mul   = 4'h8;
   localparam logic [op_w-1:0] op_div   = 4'h9;
   // Load/store buffer
   localparam logic [op_w-1:0] op_load  = 4'ha;
   localparam logic [op_w-1:0] op_store = 4'hb;

   // Operation offered by the reservation stations
   typedef struct packed {
      logic [op_w-1:0]   opcode;
      logic [data_w-1:0] rs;
      logic [data_w-1:0] rt;
      logic [tag_w-1:0]  rd_tag;
   } op_req_t;

   // Result of one execution unit, tag travels with the data
   typedef struct packed {
      logic              valid;
      logic [tag_w-1:0]  tag;
      logic [data_w-1:0] data;
   } unit_res_t;

   // Common data bus
   typedef struct packed {
      logic              valid;
      logic [tag_w-1:0]  tag;
      logic [data_w-1:0] data;
      logic              branch;
      logic              branch_taken;
   } cdb_t;

endpackage

`default_nettype wire

//--- hw/int_alu_unit.sv
`default_nettype none

module int_alu_unit import tomasulo_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  op_req_t   req,
   output unit_res_t res,
   output logic      carryout,
   output logic      overflow,
   output logic      branch,
   output logic      branch_taken
);

   // Stage one, captured operation
   logic              s1_valid;
   op_req_t           s1_req;

   logic [data_w:0]   sum_ext;
   logic [data_w:0]   diff_ext;
   logic [data_w-1:0] alu_data;
   logic              alu_carry;
   logic              alu_ovf;
   logic              alu_branch;
   logic              alu_taken;

   // Stage two, registered result
   logic              s2_valid;
   logic [tag_w-1:0]  s2_tag;
   logic [data_w-1:0] s2_data;
   logic              s2_carry;
   logic              s2_ovf;
   logic              s2_branch;
   logic              s2_taken;

   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= start;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         s1_req <= req;
      end
   end

   // 33-bit forms, bit 32 is carry out or borrow
   assign sum_ext  = {1'b0, s1_req.rs} + {1'b0, s1_req.rt};
   assign diff_ext = {1'b0, s1_req.rs} - {1'b0, s1_req.rt};

   always_comb begin
      alu_data   = '0;
      alu_carry  = 1'b0;
      alu_ovf    = 1'b0;
      alu_branch = 1'b0;
      alu_taken  = 1'b0;
      case (s1_req.opcode)
         op_add: begin
            alu_data  = sum_ext[data_w-1:0];
            alu_carry = sum_ext[data_w];
            // Like signs in, other sign out
            alu_ovf   = (s1_req.rs[data_w-1] == s1_req.rt[data_w-1])
                     && (sum_ext[data_w-1] != s1_req.rs[data_w-1]);
         end
         op_sub: begin
            alu_data  = diff_ext[data_w-1:0];
            alu_carry = diff_ext[data_w];
            alu_ovf   = (s1_req.rs[data_w-1] != s1_req.rt[data_w-1])
                     && (diff_ext[data_w-1] != s1_req.rs[data_w-1]);
         end
         op_and: alu_data = s1_req.rs & s1_req.rt;
         op_or:  alu_data = s1_req.rs | s1_req.rt;
         op_xor: alu_data = s1_req.rs ^ s1_req.rt;
         op_slt: begin
            alu_data = {{(data_w-1){1'b0}}, $signed(s1_req.rs) < $signed(s1_req.rt)};
         end
         // Branches give no data, only the outcome
         op_beq: begin
            alu_branch = 1'b1;
            alu_taken  = (s1_req.rs == s1_req.rt);
         end
         op_bne: begin
            alu_branch = 1'b1;
            alu_taken  = (s1_req.rs != s1_req.rt);
         end
         default: alu_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         s2_valid <= 1'b0;
      end else begin
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      s2_tag    <= s1_req.rd_tag;
      s2_data   <= alu_data;
      s2_carry  <= alu_carry;
      s2_ovf    <= alu_ovf;
      s2_branch <= alu_branch;
      s2_taken  <= alu_taken;
   end

   assign res          = '{valid: s2_valid, tag: s2_tag, data: s2_data};
   assign carryout     = s2_carry;
   assign overflow     = s2_ovf;
   assign branch       = s2_branch;
   assign branch_taken = s2_taken;

endmodule

`default_nettype wire

//--- hw/mult_unit.sv
`default_nettype none

module mult_unit import tomasulo_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  op_req_t   req,
   output unit_res_t res
);

   // Radix-4 partial products, then a 16-8-4-2-1 adder tree
   logic [data_w-1:0] pp1 [data_w/2];
   logic [data_w-1:0] pp2 [data_w/4];
   logic [data_w-1:0] pp3 [data_w/8];
   logic [data_w-1:0] pp4 [data_w/16];
   logic [data_w-1:0] prod;

   // Valid and tag ride alongside the tree
   logic [lat_mult-1:0] vld_sr;
   logic [tag_w-1:0]    tag_sr [lat_mult];

   // a times one 2-bit digit of b, placed at its weight
   // Bits above data_w drop off, only the low word is kept
   function automatic logic [data_w-1:0] pp_digit(input logic [data_w-1:0] a,
                                                  input logic [1:0]        d,
                                                  input int                sh);
      logic [data_w-1:0] m;
      case (d)
         2'd0:    m = '0;
         2'd1:    m = a;
         2'd2:    m = a << 1;
         default: m = a + (a << 1);
      endcase
      return m << sh;
   endfunction

   always_ff @(posedge clk) begin
      for (int i = 0; i < data_w/2; i++) begin
         pp1[i] <= pp_digit(req.rs, req.rt[2*i +: 2], 2*i);
      end
      for (int i = 0; i < data_w/4; i++) begin
         pp2[i] <= pp1[2*i] + pp1[2*i+1];
      end
      for (int i = 0; i < data_w/8; i++) begin
         pp3[i] <= pp2[2*i] + pp2[2*i+1];
      end
      for (int i = 0; i < data_w/16; i++) begin
         pp4[i] <= pp3[2*i] + pp3[2*i+1];
      end
      prod <= pp4[0] + pp4[1];
   end

   always_ff @(posedge clk) begin
      tag_sr[0] <= req.rd_tag;
      for (int i = 1; i < lat_mult; i++) begin
         tag_sr[i] <= tag_sr[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         vld_sr <= '0;
      end else begin
         vld_sr <= {vld_sr[lat_mult-2:0], start};
      end
   end

   assign res = '{valid: vld_sr[lat_mult-1], tag: tag_sr[lat_mult-1], data: prod};

endmodule

`default_nettype wire

//--- hw/div_unit.sv
`default_nettype none

module div_unit import tomasulo_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  op_req_t   req,
   output logic      div_busy,
   output unit_res_t res
);

   // Partial remainder and dividend/quotient shift word
   logic [data_w-1:0]    rem_q;
   logic [data_w-1:0]    quo_q;
   logic [data_w-1:0]    dvsr_q;
   logic [tag_w-1:0]     tag_q;
   logic [div_cnt_w-1:0] steps_left;
   logic                 done;

   // Four restoring steps, one quotient digit of radix 16
   // Dividend bits leave quo at the top while quotient bits enter at the bottom
   function automatic logic [2*data_w-1:0] div_step(input logic [data_w-1:0] rem_in,
                                                    input logic [data_w-1:0] quo_in,
                                                    input logic [data_w-1:0] dvsr);
      logic [data_w:0]   trial;
      logic [data_w-1:0] rem;
      logic [data_w-1:0] quo;
      rem = rem_in;
      quo = quo_in;
      for (int i = 0; i < div_bits; i++) begin
         trial = {rem, quo[data_w-1]};
         quo   = {quo[data_w-2:0], 1'b0};
         // A zero divisor always fits, so x/0 gives all ones
         if (trial >= {1'b0, dvsr}) begin
            trial  = trial - {1'b0, dvsr};
            quo[0] = 1'b1;
         end
         rem = trial[data_w-1:0];
      end
      return {rem, quo};
   endfunction

   // Control, busy from the edge after start until the result cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         div_busy   <= 1'b0;
         done       <= 1'b0;
         steps_left <= '0;
      end else begin
         done <= 1'b0;
         if (start) begin
            div_busy   <= 1'b1;
            steps_left <= div_cnt_w'(lat_div - 1);
         end else if (div_busy) begin
            steps_left <= steps_left - 1'b1;
            // Last digit lands now, result shows next cycle
            if (steps_left == div_cnt_w'(1)) begin
               div_busy <= 1'b0;
               done     <= 1'b1;
            end
         end
      end
   end

   // First digit is taken on the capture edge itself
   always_ff @(posedge clk) begin
      if (start) begin
         {rem_q, quo_q} <= div_step('0, req.rs, req.rt);
         dvsr_q         <= req.rt;
         tag_q          <= req.rd_tag;
      end else if (div_busy) begin
         {rem_q, quo_q} <= div_step(rem_q, quo_q, dvsr_q);
      end
   end

   assign res = '{valid: done, tag: tag_q, data: quo_q};

   // Issue must respect the busy level, there is one divider
   a_no_overlap: assert property (@(posedge clk) disable iff (reset)
      start |-> !div_busy)
      else $error("div_unit: start while a divide is in flight");

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
`default_nettype none

module load_store_unit import tomasulo_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  op_req_t   req,
   output unit_res_t res
);

   logic [data_w-1:0] mem [mem_depth];

   // Stage one, decoded access
   logic              s1_load;
   logic              s1_store;
   logic [tag_w-1:0]  s1_tag;
   logic [mem_aw-1:0] s1_addr;
   logic [data_w-1:0] s1_wdata;

   // Stage two, load data
   logic              s2_valid;
   logic [tag_w-1:0]  s2_tag;
   logic [data_w-1:0] s2_data;

   always_ff @(posedge clk) begin
      if (reset) begin
         s1_load  <= 1'b0;
         s1_store <= 1'b0;
      end else begin
         s1_load  <= start && (req.opcode == op_load);
         s1_store <= start && (req.opcode == op_store);
      end
   end

   // Address from rt, store data from rs
   always_ff @(posedge clk) begin
      s1_tag   <= req.rd_tag;
      s1_addr  <= req.rt[mem_aw-1:0];
      s1_wdata <= req.rs;
   end

   // Store commits in stage one, so a load one cycle behind sees it
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < mem_depth; i++) begin
            mem[i] <= '0;
         end
      end else if (s1_store) begin
         mem[s1_addr] <= s1_wdata;
      end
   end

   // Stores keep their CDB slot but never drive valid
   always_ff @(posedge clk) begin
      if (reset) begin
         s2_valid <= 1'b0;
      end else begin
         s2_valid <= s1_load;
      end
   end

   always_ff @(posedge clk) begin
      s2_tag  <= s1_tag;
      s2_data <= mem[s1_addr];
   end

   assign res = '{valid: s2_valid, tag: s2_tag, data: s2_data};

endmodule

`default_nettype wire

//--- hw/issue_unit.sv
`default_nettype none

module issue_unit import tomasulo_pkg::*; (
   input  logic    clk,
   input  logic    reset,

   input  op_req_t req,
   input  logic    ready_int,
   input  logic    ready_mult,
   input  logic    ready_div,
   input  logic    ready_ls,

   output logic    issue_int,
   output logic    issue_mult,
   output logic    issue_div,
   output logic    issue_ls,
   output logic    carryout,
   output logic    overflow,
   output cdb_t    cdb
);

   // Bit i marks a broadcast already owned for cycle now + i + 1
   logic [slot_count-1:0] cdb_slot;
   logic [slot_count-1:0] grant_mask;
   // High when load/store was granted less recently than integer
   logic                  pick_ls;

   logic                  ok_int;
   logic                  ok_mult;
   logic                  ok_div;
   logic                  ok_ls;
   logic                  div_busy;

   unit_res_t             int_res;
   unit_res_t             mult_res;
   unit_res_t             div_res;
   unit_res_t             ls_res;
   unit_res_t             any_res;

   logic                  alu_carry;
   logic                  alu_ovf;
   logic                  alu_branch;
   logic                  alu_taken;

   // Zero a result unless its unit is broadcasting
   function automatic unit_res_t gate_res(input unit_res_t r);
      unit_res_t g;
      g = '0;
      if (r.valid) begin
         g = r;
      end
      return g;
   endfunction

   // A unit may go if it has work and its landing cycle is free
   assign ok_int  = ready_int  && !cdb_slot[lat_int-1];
   assign ok_ls   = ready_ls   && !cdb_slot[lat_ls-1];
   assign ok_mult = ready_mult && !cdb_slot[lat_mult-1];
   assign ok_div  = ready_div  && !cdb_slot[lat_div-1] && !div_busy;

   // Fixed priority, int/ls pair first, then mult, then div
   always_comb begin
      issue_int  = 1'b0;
      issue_mult = 1'b0;
      issue_div  = 1'b0;
      issue_ls   = 1'b0;
      if (ok_int && ok_ls) begin
         // Both eligible, least recently granted wins
         issue_int = !pick_ls;
         issue_ls  = pick_ls;
      end else if (ok_int) begin
         issue_int = 1'b1;
      end else if (ok_ls) begin
         issue_ls = 1'b1;
      end else if (ok_mult) begin
         issue_mult = 1'b1;
      end else if (ok_div) begin
         issue_div = 1'b1;
      end
   end

   // Landing cycle of this cycle's grant
   always_comb begin
      grant_mask                = '0;
      grant_mask[lat_int-1]     = issue_int;
      grant_mask[lat_ls-1]      = grant_mask[lat_ls-1] | issue_ls;
      grant_mask[lat_mult-1]    = grant_mask[lat_mult-1] | issue_mult;
      grant_mask[lat_div-1]     = grant_mask[lat_div-1] | issue_div;
   end

   // Reserve, then slide one cycle closer to now
   always_ff @(posedge clk) begin
      if (reset) begin
         cdb_slot <= '0;
      end else begin
         cdb_slot <= (cdb_slot | grant_mask) >> 1;
      end
   end

   // Starts out favouring integer
   always_ff @(posedge clk) begin
      if (reset) begin
         pick_ls <= 1'b0;
      end else if (issue_int) begin
         pick_ls <= 1'b1;
      end else if (issue_ls) begin
         pick_ls <= 1'b0;
      end
   end

   int_alu_unit u_int (
      .clk          (clk),
      .reset        (reset),
      .start        (issue_int),
      .req          (req),
      .res          (int_res),
      .carryout     (alu_carry),
      .overflow     (alu_ovf),
      .branch       (alu_branch),
      .branch_taken (alu_taken)
   );

   mult_unit u_mult (
      .clk   (clk),
      .reset (reset),
      .start (issue_mult),
      .req   (req),
      .res   (mult_res)
   );

   div_unit u_div (
      .clk      (clk),
      .reset    (reset),
      .start    (issue_div),
      .req      (req),
      .div_busy (div_busy),
      .res      (div_res)
   );

   load_store_unit u_ls (
      .clk   (clk),
      .reset (reset),
      .start (issue_ls),
      .req   (req),
      .res   (ls_res)
   );

   // Slots make the results one-hot, so an OR of gated results is the mux
   assign any_res = gate_res(int_res) | gate_res(mult_res) | gate_res(div_res)
                  | gate_res(ls_res);

   assign cdb = '{valid:        any_res.valid,
                  tag:          any_res.tag,
                  data:         any_res.data,
                  branch:       int_res.valid & alu_branch,
                  branch_taken: int_res.valid & alu_taken};

   // Flags only mean something beside an ALU result
   assign carryout = int_res.valid & alu_carry;
   assign overflow = int_res.valid & alu_ovf;

   a_slot_free: assert property (@(posedge clk) disable iff (reset)
      (grant_mask & cdb_slot) == '0)
      else $error("issue_unit: grant into a reserved CDB cycle");

   // Unit latencies and slot bookkeeping have to agree
   a_one_result: assert property (@(posedge clk) disable iff (reset)
      $onehot0({int_res.valid, mult_res.valid, div_res.valid, ls_res.valid}))
      else $error("issue_unit: two units broadcast in one cycle");

endmodule

`default_nettype wire

//--- verif/tb_issue_unit.sv
`default_nettype none

module tb_issue_unit import tomasulo_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   // Unit numbering inside the testbench
   localparam int unit_int  = 0;
   localparam int unit_mult = 1;
   localparam int unit_div  = 2;
   localparam int unit_ls   = 3;

   // Roughly twice the summed length of all tests
   localparam int max_cycles = 260;
   localparam int bus_depth  = max_cycles + slot_count + 4;

   logic    clk;
   logic    reset;
   op_req_t req;
   logic    ready_int;
   logic    ready_mult;
   logic    ready_div;
   logic    ready_ls;
   logic    issue_int;
   logic    issue_mult;
   logic    issue_div;
   logic    issue_ls;
   logic    carryout;
   logic    overflow;
   cdb_t    cdb;

   int               cycle = 0;
   int               errors = 0;
   int               last_exp = 0;
   logic [tag_w-1:0] next_tag = '0;

   // Expected bus per cycle, zero means no broadcast
   cdb_t              exp_bus   [bus_depth];
   logic              exp_carry [bus_depth];
   logic              exp_ovf   [bus_depth];
   // Reference copy of the load/store data
   logic [data_w-1:0] mem_model [mem_depth];

   issue_unit uut (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .ready_int  (ready_int),
      .ready_mult (ready_mult),
      .ready_div  (ready_div),
      .ready_ls   (ready_ls),
      .issue_int  (issue_int),
      .issue_mult (issue_mult),
      .issue_div  (issue_div),
      .issue_ls   (issue_ls),
      .carryout   (carryout),
      .overflow   (overflow),
      .cdb        (cdb)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Cycle count and run limit
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= max_cycles) begin
         $display("timeout: tests still running after %0d cycles", cycle);
         $display("errors: %0d", errors);
         $display("TEST FAIL");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("error: %s is 0x%0h, expected 0x%0h in cycle %0d", name, got, exp, cycle);
      end
   endtask

   function automatic op_req_t make_op(input logic [op_w-1:0] opcode,
                                       input logic [data_w-1:0] a,
                                       input logic [data_w-1:0] b);
      op_req_t o;
      o.opcode = opcode;
      o.rs     = a;
      o.rt     = b;
      o.rd_tag = next_tag;
      next_tag = next_tag + 1'b1;
      return o;
   endfunction

   function automatic int latency(input int unit);
      case (unit)
         unit_int:  return lat_int;
         unit_mult: return lat_mult;
         unit_div:  return lat_div;
         default:   return lat_ls;
      endcase
   endfunction

   function automatic logic granted(input int unit);
      case (unit)
         unit_int:  return issue_int;
         unit_mult: return issue_mult;
         unit_div:  return issue_div;
         default:   return issue_ls;
      endcase
   endfunction

   // Reference ALU on 64-bit integers
   task automatic alu_model(input logic [op_w-1:0] op, input logic [data_w-1:0] a,
                            input logic [data_w-1:0] b, output logic [data_w-1:0] d,
                            output logic c, output logic v, output logic br,
                            output logic tk);
      longint     sa;
      longint     sb;
      longint     sr;
      logic [63:0] wide;
      sa = $signed(a);
      sb = $signed(b);
      d  = '0;
      c  = 1'b0;
      v  = 1'b0;
      br = 1'b0;
      tk = 1'b0;
      case (op)
         op_add: begin
            d    = a + b;
            wide = 64'(a) + 64'(b);
            c    = wide > 64'hffff_ffff;
            sr   = sa + sb;
            // Overflow when the signed sum does not fit in 32 bits
            v    = sr != longint'($signed(d));
         end
         op_sub: begin
            d  = a - b;
            // Borrow
            c  = a < b;
            sr = sa - sb;
            v  = sr != longint'($signed(d));
         end
         op_and: d = a & b;
         op_or:  d = a | b;
         op_xor: d = a ^ b;
         op_slt: d = (sa < sb) ? 32'd1 : 32'd0;
         op_beq: begin
            br = 1'b1;
            tk = a == b;
         end
         op_bne: begin
            br = 1'b1;
            tk = a != b;
         end
         default: d = '0;
      endcase
   endtask

   // Record what the bus must show at grant plus latency
   task automatic predict(input int unit, input op_req_t op, input int gcycle);
      int                at;
      cdb_t              e;
      logic [data_w-1:0] d;
      logic [63:0]       prod;
      logic              c;
      logic              v;
      logic              br;
      logic              tk;
      at = gcycle + latency(unit);
      e  = '0;
      c  = 1'b0;
      v  = 1'b0;
      case (unit)
         unit_int: begin
            alu_model(op.opcode, op.rs, op.rt, d, c, v, br, tk);
            e = '{valid: 1'b1, tag: op.rd_tag, data: d, branch: br, branch_taken: tk};
         end
         unit_mult: begin
            prod = 64'(op.rs) * 64'(op.rt);
            e    = '{valid: 1'b1, tag: op.rd_tag, data: prod[31:0], branch: 1'b0,
                     branch_taken: 1'b0};
         end
         unit_div: begin
            d = (op.rt == 0) ? 32'hffff_ffff : op.rs / op.rt;
            e = '{valid: 1'b1, tag: op.rd_tag, data: d, branch: 1'b0, branch_taken: 1'b0};
         end
         default: begin
            // Store holds its slot silently
            if (op.opcode == op_store) begin
               mem_model[op.rt[mem_aw-1:0]] = op.rs;
            end else if (op.opcode == op_load) begin
               e.valid = 1'b1;
               e.tag   = op.rd_tag;
               e.data  = mem_model[op.rt[mem_aw-1:0]];
            end
         end
      endcase
      exp_bus[at]   = e;
      exp_carry[at] = c;
      exp_ovf[at]   = v;
      if (at > last_exp) begin
         last_exp = at;
      end
   endtask

   // Bus monitor, every cycle against the expected table
   task automatic compare_bus();
      cdb_t e;
      e = exp_bus[cycle];
      check_value("cdb.valid", cdb.valid, e.valid);
      if (e.valid) begin
         check_value("cdb.tag", cdb.tag, e.tag);
         check_value("cdb.data", cdb.data, e.data);
         check_value("cdb.branch", cdb.branch, e.branch);
         check_value("cdb.branch_taken", cdb.branch_taken, e.branch_taken);
         check_value("carryout", carryout, exp_carry[cycle]);
         check_value("overflow", overflow, exp_ovf[cycle]);
      end
   endtask

   always @(negedge clk) begin
      if (!reset) begin
         compare_bus();
      end
   end

   // Present an operation, wait for its grant, note the result
   task automatic issue_op(input int unit, input op_req_t op, output int gcycle);
      @(posedge clk);
      req <= op;
      case (unit)
         unit_int:  ready_int  <= 1'b1;
         unit_mult: ready_mult <= 1'b1;
         unit_div:  ready_div  <= 1'b1;
         default:   ready_ls   <= 1'b1;
      endcase
      @(negedge clk);
      while (!granted(unit)) begin
         @(negedge clk);
      end
      gcycle = cycle;
      predict(unit, op, gcycle);
   endtask

   task automatic drop_ready();
      @(posedge clk);
      ready_int  <= 1'b0;
      ready_mult <= 1'b0;
      ready_div  <= 1'b0;
      ready_ls   <= 1'b0;
      @(negedge clk);
   endtask

   // Let every outstanding result reach the bus
   task automatic drain();
      drop_ready();
      while (cycle <= last_exp + 1) begin
         @(negedge clk);
      end
   endtask

   task automatic arbitration_test();
      op_req_t op;
      int      last;
      op = make_op(op_add, $urandom, $urandom);
      @(posedge clk);
      req        <= op;
      ready_int  <= 1'b1;
      ready_ls   <= 1'b1;
      ready_mult <= 1'b1;
      // Pair alternates from integer, multiply starves meanwhile
      for (int i = 0; i < 6; i++) begin
         @(negedge clk);
         check_value("issue_int", issue_int, (i % 2) == 0);
         check_value("issue_ls", issue_ls, (i % 2) == 1);
         check_value("issue_mult", issue_mult, 1'b0);
         if (issue_int) begin
            predict(unit_int, op, cycle);
         end
         if (issue_ls) begin
            predict(unit_ls, op, cycle);
         end
         last = cycle;
      end
      @(posedge clk);
      ready_int <= 1'b0;
      ready_ls  <= 1'b0;
      @(negedge clk);
      while (!issue_mult) begin
         @(negedge clk);
      end
      check_value("mult grant cycle", cycle, last + 1);
      predict(unit_mult, op, cycle);
      drain();
   endtask

   task automatic integer_test();
      logic [op_w-1:0]   ops [8];
      logic [data_w-1:0] a;
      logic [data_w-1:0] b;
      int                g;
      ops = '{op_add, op_sub, op_and, op_or, op_xor, op_slt, op_beq, op_bne};
      // Signed overflow and carry corners
      issue_op(unit_int, make_op(op_add, 32'h7fff_ffff, 32'h1), g);
      issue_op(unit_int, make_op(op_add, 32'hffff_ffff, 32'h1), g);
      issue_op(unit_int, make_op(op_sub, 32'h8000_0000, 32'h1), g);
      issue_op(unit_int, make_op(op_sub, 32'h1, 32'h2), g);
      for (int r = 0; r < 3; r++) begin
         for (int k = 0; k < 8; k++) begin
            a = $urandom;
            // Equal operands on the first pass so branches go both ways
            b = (r == 0 && k >= 6) ? a : $urandom;
            issue_op(unit_int, make_op(ops[k], a, b), g);
         end
      end
      drain();
   endtask

   task automatic multiply_test();
      int g0;
      int g1;
      int g2;
      issue_op(unit_mult, make_op(op_mul, $urandom, $urandom), g0);
      issue_op(unit_mult, make_op(op_mul, 32'hffff_ffff, 32'hffff_ffff), g1);
      issue_op(unit_mult, make_op(op_mul, $urandom, 32'd3), g2);
      check_value("second mult grant cycle", g1, g0 + 1);
      check_value("third mult grant cycle", g2, g1 + 1);
      drain();
   endtask

   task automatic divide_test();
      int g0;
      int g1;
      int g2;
      issue_op(unit_div, make_op(op_div, $urandom, ($urandom % 1000) + 1), g0);
      // Held request must wait out the busy divider
      issue_op(unit_div, make_op(op_div, $urandom, 32'h0), g1);
      check_value("second div grant cycle", g1, g0 + lat_div);
      issue_op(unit_div, make_op(op_div, 32'd100, 32'd7), g2);
      check_value("third div grant cycle", g2, g1 + lat_div);
      drain();
   endtask

   task automatic load_store_test();
      logic [data_w-1:0] hi;
      int                g;
      hi = $urandom & 32'hffff_fff0;
      issue_op(unit_ls, make_op(op_store, $urandom, 32'd3), g);
      issue_op(unit_ls, make_op(op_store, $urandom, hi | 32'd7), g);
      issue_op(unit_ls, make_op(op_store, $urandom, 32'd12), g);
      issue_op(unit_ls, make_op(op_store, $urandom, 32'd0), g);
      // Load right behind a store to the same word
      issue_op(unit_ls, make_op(op_store, $urandom, 32'd9), g);
      issue_op(unit_ls, make_op(op_load, 32'h0, 32'd9), g);
      // Only the low four address bits count
      issue_op(unit_ls, make_op(op_load, 32'h0, hi | 32'd12), g);
      issue_op(unit_ls, make_op(op_load, 32'h0, 32'd3), g);
      issue_op(unit_ls, make_op(op_load, 32'h0, 32'd0), g);
      issue_op(unit_ls, make_op(op_load, 32'h0, 32'd7), g);
      // Never written since reset
      issue_op(unit_ls, make_op(op_load, 32'h0, 32'd5), g);
      drain();
   endtask

   task automatic collision_test();
      int t;
      int g;
      issue_op(unit_mult, make_op(op_mul, $urandom, $urandom), t);
      drop_ready();
      while (cycle < t + 2) begin
         @(negedge clk);
      end
      // Raised in t + 3, would land on the multiply at t + 5
      issue_op(unit_int, make_op(op_xor, $urandom, $urandom), g);
      check_value("int grant cycle after mult", g, t + 4);
      drain();
   endtask

   initial begin
      void'($urandom(32'h1d99));
      for (int i = 0; i < bus_depth; i++) begin
         exp_bus[i]   = '0;
         exp_carry[i] = 1'b0;
         exp_ovf[i]   = 1'b0;
      end
      for (int i = 0; i < mem_depth; i++) begin
         mem_model[i] = '0;
      end
      reset      <= 1'b1;
      req        <= '0;
      ready_int  <= 1'b0;
      ready_mult <= 1'b0;
      ready_div  <= 1'b0;
      ready_ls   <= 1'b0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      // Arbitration first, the pair favours integer only straight after reset
      arbitration_test();
      integer_test();
      multiply_test();
      divide_test();
      load_store_test();
      collision_test();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
hw/tomasulo_pkg.sv
hw/int_alu_unit.sv
hw/mult_unit.sv
hw/div_unit.sv
hw/load_store_unit.sv
hw/issue_unit.sv
verif/tb_issue_unit.sv

//--- Makefile
# Verilator simulation of the issue unit testbench

VERILATOR ?= verilator
TOP       ?= tb_issue_unit
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
